/* Bender.yml */
package:
  name: copad_finder

sources:
  # design, in compile order
  - hdl/copad_pkg.sv
  - hdl/pad_overlap.sv
  - hdl/roll_adjacency.sv
  - hdl/copad_combine.sv
  - hdl/copad_finder.sv

  # testbench
  - target: test
    files:
      - tb/copad_props.sv
      - tb/copad_finder_tb.sv

/* copad_finder.f */
hdl/copad_pkg.sv
hdl/pad_overlap.sv
hdl/roll_adjacency.sv
hdl/copad_combine.sv
hdl/copad_finder.sv
tb/copad_props.sv
tb/copad_finder_tb.sv

/* hdl/copad_combine.sv */
//--------------------------------------------------
// merges pad overlap and roll relation per A cluster
// all outputs registered, one cycle after the inputs
//--------------------------------------------------
`timescale 1ns/1ps

module copad_combine (
    input  logic                    clock,
    input  logic                    rst,
    input  copad_pkg::pair_matrix_t overlap,
    input  copad_pkg::roll_rel_t    rel,
    input  logic                    neighbor_roll,
    output copad_pkg::match_vec_t   match,
    output copad_pkg::match_vec_t   match_upper,
    output copad_pkg::match_vec_t   match_lower,
    output logic                    any_match
);

    import copad_pkg::*;

    match_vec_t match_same;
    match_vec_t match_up;     // B below A with pad overlap
    match_vec_t match_lo;     // B above A with pad overlap
    match_vec_t match_full;

    // OR across B clusters per A cluster
    always_comb begin : reduce_b
        for (int i = 0; i < num_clusters; i++) begin
            match_same[i] = |(rel.same[i]  & overlap[i]);
            match_up[i]   = |(rel.upper[i] & overlap[i]);
            match_lo[i]   = |(rel.lower[i] & overlap[i]);
        end
    end

    // neighbor rolls count only when enabled
    assign match_full = match_same
                      | ({num_clusters{neighbor_roll}} & (match_up | match_lo));

    //--------------------------------------------------
    // output registers
    //--------------------------------------------------
    always_ff @(posedge clock) begin
        if (rst) begin
            match       <= '0;
            match_upper <= '0;
            match_lower <= '0;
            any_match   <= 1'b0;
        end else begin
            match       <= match_full;
            match_upper <= match_up;    // reported whatever the enable
            match_lower <= match_lo;
            any_match   <= |match_full;
        end
    end

endmodule

/* hdl/copad_finder.sv */
//--------------------------------------------------
// coincidence pad finder for GEM chambers A and B
// inputs sampled every clock, results one cycle later
//--------------------------------------------------
`timescale 1ns/1ps

module copad_finder (
    input  logic                    clock,
    input  logic                    rst,
    input  copad_pkg::cluster_set_t gem_a,
    input  copad_pkg::cluster_set_t gem_b,
    input  copad_pkg::match_cfg_t   cfg,
    output copad_pkg::match_vec_t   match,
    output copad_pkg::match_vec_t   match_upper,
    output copad_pkg::match_vec_t   match_lower,
    output logic                    any_match
);

    import copad_pkg::*;

    pair_matrix_t overlap;   // pad half of the test
    roll_rel_t    rel;       // roll half of the test

    //--------------------------------------------------
    // the two matrices work side by side
    //--------------------------------------------------
    pad_overlap u_pad_overlap (
        .gem_a   (gem_a),
        .gem_b   (gem_b),
        .cfg     (cfg),
        .overlap (overlap)
    );

    roll_adjacency u_roll_adjacency (
        .gem_a (gem_a),
        .gem_b (gem_b),
        .rel   (rel)
    );

    copad_combine u_copad_combine (
        .clock         (clock),
        .rst           (rst),
        .overlap       (overlap),
        .rel           (rel),
        .neighbor_roll (cfg.neighbor_roll),
        .match         (match),
        .match_upper   (match_upper),
        .match_lower   (match_lower),
        .any_match     (any_match)
    );

endmodule

/* hdl/copad_pkg.sv */
//--------------------------------------------------
// geometry and types shared by the copad finder
// pads above max_pad are outside the design's range
//--------------------------------------------------
package copad_pkg;

    //--------------------------------------------------
    // chamber geometry
    //--------------------------------------------------
    localparam int num_clusters = 8;   // clusters per chamber per clock
    localparam int roll_w       = 3;
    localparam int pad_w        = 8;
    localparam int cnt_w        = 3;   // extra pads beyond the start pad
    localparam int delta_w      = 4;
    localparam int max_pad      = 191;
    localparam int max_roll     = 7;

    //--------------------------------------------------
    // cluster words
    //--------------------------------------------------
    typedef struct packed {
        logic              vpf;    // cluster present
        logic [roll_w-1:0] roll;   // eta partition
        logic [pad_w-1:0]  pad;    // first pad of the cluster
        logic [cnt_w-1:0]  cnt;    // additional pads hit
    } cluster_t;

    // one chamber, one clock
    typedef cluster_t [num_clusters-1:0] cluster_set_t;

    typedef struct packed {
        logic               neighbor_roll;  // fold upper/lower into match
        logic               neighbor_pad;   // widen window by delta_pad
        logic [delta_w-1:0] delta_pad;
    } match_cfg_t;

    //--------------------------------------------------
    // match results
    //--------------------------------------------------
    // first index is the A cluster, second the B cluster
    typedef logic [num_clusters-1:0][num_clusters-1:0] pair_matrix_t;

    typedef struct packed {
        pair_matrix_t same;    // B in the same roll
        pair_matrix_t upper;   // B one roll below A
        pair_matrix_t lower;   // B one roll above A
    } roll_rel_t;

    typedef logic [num_clusters-1:0] match_vec_t;  // one bit per A cluster

endpackage

/* hdl/pad_overlap.sv */
//--------------------------------------------------
// pad overlap of every A/B cluster pair, combinational
// B matches if its first or last pad is in the A window
//--------------------------------------------------
`timescale 1ns/1ps

module pad_overlap (
    input  copad_pkg::cluster_set_t gem_a,
    input  copad_pkg::cluster_set_t gem_b,
    input  copad_pkg::match_cfg_t   cfg,
    output copad_pkg::pair_matrix_t overlap
);

    import copad_pkg::*;

    logic [pad_w-1:0] delta;                    // effective window widening
    logic [pad_w-1:0] win_lo  [num_clusters];
    logic [pad_w-1:0] win_hi  [num_clusters];
    logic [pad_w-1:0] b_first [num_clusters];
    logic [pad_w-1:0] b_last  [num_clusters];

    function automatic logic in_window(
        input logic [pad_w-1:0] p,
        input logic [pad_w-1:0] lo,
        input logic [pad_w-1:0] hi
    );
        return (p >= lo) && (p <= hi);
    endfunction

    assign delta = cfg.neighbor_pad ? pad_w'(cfg.delta_pad) : '0;

    //--------------------------------------------------
    // A windows, clamped to the roll edges
    //--------------------------------------------------
    always_comb begin : a_window
        logic [pad_w-1:0] span;
        for (int i = 0; i < num_clusters; i++) begin
            // pad + cnt + delta stays below 256, no wrap
            span = gem_a[i].pad + pad_w'(gem_a[i].cnt) + delta;
            win_lo[i] = (gem_a[i].pad < delta) ? '0 : gem_a[i].pad - delta;
            win_hi[i] = (span > pad_w'(max_pad)) ? pad_w'(max_pad) : span;
        end
    end

    // B cluster extent
    always_comb begin : b_extent
        for (int j = 0; j < num_clusters; j++) begin
            b_first[j] = gem_b[j].pad;
            b_last[j]  = gem_b[j].pad + pad_w'(gem_b[j].cnt);
        end
    end

    //--------------------------------------------------
    // 64 pair tests
    //--------------------------------------------------
    always_comb begin : pair_test
        for (int i = 0; i < num_clusters; i++) begin
            for (int j = 0; j < num_clusters; j++) begin
                // a B cluster covering the whole window with both ends
                // outside it is not counted
                overlap[i][j] = in_window(b_first[j], win_lo[i], win_hi[i])
                              | in_window(b_last[j], win_lo[i], win_hi[i]);
            end
        end
    end

endmodule

/* hdl/roll_adjacency.sv */
//--------------------------------------------------
// roll relation of every valid A/B cluster pair
// combinational, pads are not looked at here
//--------------------------------------------------
`timescale 1ns/1ps

module roll_adjacency (
    input  copad_pkg::cluster_set_t gem_a,
    input  copad_pkg::cluster_set_t gem_b,
    output copad_pkg::roll_rel_t    rel
);

    import copad_pkg::*;

    //--------------------------------------------------
    // same / below / above classification
    //--------------------------------------------------
    always_comb begin : classify
        logic              both_valid;
        logic              a_top;        // A in the last roll
        logic              a_bottom;     // A in roll 0
        logic [roll_w-1:0] a_next;       // wraps at max_roll
        logic [roll_w-1:0] b_next;
        for (int i = 0; i < num_clusters; i++) begin
            a_next   = gem_a[i].roll + roll_w'(1);
            a_top    = (gem_a[i].roll == roll_w'(max_roll));
            a_bottom = (gem_a[i].roll == '0);
            for (int j = 0; j < num_clusters; j++) begin
                b_next     = gem_b[j].roll + roll_w'(1);
                both_valid = gem_a[i].vpf & gem_b[j].vpf;

                rel.same[i][j] = both_valid && (gem_a[i].roll == gem_b[j].roll);

                // B one roll below A; roll 0 has nothing below,
                // the wrapped b_next would fake one from roll 7
                rel.upper[i][j] = both_valid && !a_bottom
                                && (gem_a[i].roll == b_next);

                // B one roll above A, none above the last roll
                rel.lower[i][j] = both_valid && !a_top
                                && (a_next == gem_b[j].roll);
            end
        end
    end

endmodule

/* tb/copad_finder_tb.sv */
//--------------------------------------------------
// directed and random tests of copad_finder
// results are checked at the falling edge one cycle after each set
//--------------------------------------------------
`timescale 1ns/1ps

module copad_finder_tb;

    import copad_pkg::*;

    typedef struct packed {
        match_vec_t match;
        match_vec_t upper;
        match_vec_t lower;
        logic       any;
    } result_t;

    logic         clock;
    logic         rst;
    cluster_set_t gem_a;
    cluster_set_t gem_b;
    match_cfg_t   cfg;
    match_vec_t   match;
    match_vec_t   match_upper;
    match_vec_t   match_lower;
    logic         any_match;

    int          pass_count  = 0;
    int          fail_count  = 0;
    int          test_errors = 0;
    logic [31:0] rng_state   = 32'hfbe1;

    copad_finder uut (
        .clock       (clock),
        .rst         (rst),
        .gem_a       (gem_a),
        .gem_b       (gem_b),
        .cfg         (cfg),
        .match       (match),
        .match_upper (match_upper),
        .match_lower (match_lower),
        .any_match   (any_match)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    //--------------------------------------------------
    // reference model and helpers
    //--------------------------------------------------
    function automatic cluster_t make_cluster(input logic v, input int roll, input int pad,
                                              input int cnt);
        cluster_t cl;
        cl.vpf  = v;
        cl.roll = roll_w'(roll);
        cl.pad  = pad_w'(pad);
        cl.cnt  = cnt_w'(cnt);
        return cl;
    endfunction

    function automatic result_t reference_result(input cluster_set_t a, input cluster_set_t b,
                                                 input match_cfg_t c);
        result_t    r;
        match_vec_t ms;
        int         d, lo, hi, b_lo, b_hi, ar, br;
        logic       ov;
        r  = '0;
        ms = '0;
        d  = c.neighbor_pad ? int'(c.delta_pad) : 0;
        for (int i = 0; i < num_clusters; i++) begin
            lo = int'(a[i].pad) - d;
            if (lo < 0) lo = 0;
            hi = int'(a[i].pad) + int'(a[i].cnt) + d;
            if (hi > max_pad) hi = max_pad;
            ar = a[i].roll;
            for (int j = 0; j < num_clusters; j++) begin
                br   = b[j].roll;
                b_lo = b[j].pad;
                b_hi = b_lo + int'(b[j].cnt);
                ov   = (b_lo >= lo && b_lo <= hi) || (b_hi >= lo && b_hi <= hi);
                if (a[i].vpf && b[j].vpf && ov) begin
                    if (ar == br) ms[i] = 1'b1;
                    if (ar > 0 && ar == br + 1) r.upper[i] = 1'b1;        // B below A
                    if (ar < max_roll && ar + 1 == br) r.lower[i] = 1'b1; // B above A
                end
            end
        end
        r.match = c.neighbor_roll ? (ms | r.upper | r.lower) : ms;
        r.any   = |r.match;
        return r;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_random(output logic [31:0] v);
        rng_state = xorshift32(rng_state);
        v = rng_state;
    endtask

    // pads gathered into one 48-pad band so that overlaps are common
    task automatic build_random_set(output cluster_set_t s, input int base);
        logic [31:0] r;
        for (int k = 0; k < num_clusters; k++) begin
            next_random(r);
            s[k].vpf  = (r[1:0] != 2'b00);
            s[k].roll = r[4:2];
            s[k].pad  = pad_w'(base + int'(r[15:8]) % 48);
            s[k].cnt  = r[18:16];
        end
    endtask

    task automatic check_field(input string name, input logic [7:0] expected,
                               input logic [7:0] actual, input string tag);
        if (actual !== expected) begin
            $display("mismatch %s: expected %h, actual %h (%s)", name, expected, actual, tag);
            fail_count++;
            test_errors++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic compare_outputs(input result_t e, input string tag);
        check_field("match", e.match, match, tag);
        check_field("match_upper", e.upper, match_upper, tag);
        check_field("match_lower", e.lower, match_lower, tag);
        check_field("any_match", {7'b0, e.any}, {7'b0, any_match}, tag);
    endtask

    task automatic drive_and_compare(input cluster_set_t a, input cluster_set_t b,
                                     input match_cfg_t c, input string tag);
        @(posedge clock);
        gem_a <= a;
        gem_b <= b;
        cfg   <= c;
        @(posedge clock);   // set sampled here
        @(negedge clock);
        compare_outputs(reference_result(a, b, c), tag);
    endtask

    task automatic wait_for_outputs(input result_t e, input int limit, input string what);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while ({match, match_upper, match_lower, any_match} !== e && cycles < limit) begin
            @(negedge clock);
            cycles++;
        end
        if ({match, match_upper, match_lower, any_match} !== e) begin
            $display("timeout while waiting for %s", what);
            fail_count++;
            test_errors++;
        end
    endtask

    task automatic report_test(input string name);
        $display("%s finished with %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    //--------------------------------------------------
    // directed tests
    //--------------------------------------------------
    task automatic exact_pad_match();
        cluster_set_t a, b;
        match_cfg_t   c;
        a = '0;
        b = '0;
        c = '0;
        a[0] = make_cluster(1, 3, 50, 2);
        b[0] = make_cluster(1, 3, 50, 2);
        a[1] = make_cluster(1, 5, 100, 1);  // window 100..101
        b[1] = make_cluster(1, 5, 102, 0);
        b[2] = make_cluster(1, 5, 97, 2);   // ends at 99
        drive_and_compare(a, b, c, "exact");
        check_field("match", 8'h01, match, "exact by hand");
        report_test("exact pad match");
    endtask

    task automatic delta_window();
        cluster_set_t a, b;
        match_cfg_t   c;
        a = '0;
        b = '0;
        c = '{neighbor_roll: 1'b0, neighbor_pad: 1'b1, delta_pad: 4'd5};
        a[0] = make_cluster(1, 1, 2, 0);    // low end clamped to 0
        b[0] = make_cluster(1, 1, 0, 0);
        drive_and_compare(a, b, c, "delta 5");
        check_field("match", 8'h01, match, "low clamp by hand");
        c.delta_pad = 4'd4;
        a[0] = make_cluster(1, 2, 188, 3);  // high end clamped to 191
        b[0] = make_cluster(1, 2, 191, 0);
        a[1] = make_cluster(1, 4, 100, 2);  // window 96..106
        b[1] = make_cluster(1, 4, 96, 0);
        b[2] = make_cluster(1, 4, 107, 0);
        b[3] = make_cluster(1, 4, 92, 3);
        a[2] = make_cluster(1, 6, 50, 0);   // window 46..54
        b[4] = make_cluster(1, 6, 54, 0);
        b[5] = make_cluster(1, 6, 55, 1);
        b[6] = make_cluster(1, 6, 43, 2);
        drive_and_compare(a, b, c, "delta 4");
        check_field("match", 8'h07, match, "window edges by hand");
        report_test("delta window");
    endtask

    task automatic neighbor_roll_folding();
        cluster_set_t a, b;
        match_cfg_t   c;
        a = '0;
        b = '0;
        c = '0;
        a[0] = make_cluster(1, 3, 60, 1);
        b[0] = make_cluster(1, 2, 60, 0);   // below A0
        b[1] = make_cluster(1, 4, 61, 0);   // above A0
        a[1] = make_cluster(1, 0, 20, 0);
        b[2] = make_cluster(1, 7, 20, 0);   // no roll below 0
        b[3] = make_cluster(1, 1, 20, 0);
        a[2] = make_cluster(1, 7, 140, 0);
        b[4] = make_cluster(1, 0, 140, 0);  // no roll above 7
        b[5] = make_cluster(1, 6, 140, 0);
        drive_and_compare(a, b, c, "neighbors off");
        check_field("match_upper", 8'h05, match_upper, "upper by hand");
        check_field("match_lower", 8'h03, match_lower, "lower by hand");
        check_field("match", 8'h00, match, "folding off by hand");
        c.neighbor_roll = 1'b1;
        drive_and_compare(a, b, c, "neighbors on");
        check_field("match", 8'h07, match, "folding on by hand");
        report_test("neighbor roll folding");
    endtask

    task automatic validity_and_reset();
        cluster_set_t a, b;
        match_cfg_t   c;
        a = '0;
        b = '0;
        c = '{neighbor_roll: 1'b1, neighbor_pad: 1'b1, delta_pad: 4'd3};
        a[0] = make_cluster(0, 2, 30, 1);
        b[0] = make_cluster(0, 2, 30, 1);
        a[1] = make_cluster(1, 4, 70, 0);
        b[1] = make_cluster(0, 4, 70, 0);
        a[2] = make_cluster(0, 6, 120, 2);
        b[2] = make_cluster(1, 6, 120, 2);
        drive_and_compare(a, b, c, "invalid");
        check_field("match", 8'h00, match, "invalid by hand");
        a[3] = make_cluster(1, 5, 80, 0);
        b[3] = make_cluster(1, 5, 80, 0);
        drive_and_compare(a, b, c, "before reset");
        @(posedge clock);
        rst <= 1'b1;
        @(posedge clock);   // rst seen here
        rst <= 1'b0;
        @(negedge clock);
        compare_outputs('0, "after reset");
        wait_for_outputs(reference_result(a, b, c), 8, "outputs to return after reset");
        report_test("validity and reset");
    endtask

    //--------------------------------------------------
    // random sets on consecutive cycles
    //--------------------------------------------------
    task automatic random_back_to_back();
        cluster_set_t a, b;
        match_cfg_t   c;
        result_t      prev;
        logic [31:0]  r;
        prev = '0;
        for (int n = 0; n < 200; n++) begin
            next_random(r);
            c.neighbor_roll = r[2];
            c.neighbor_pad  = r[3];
            c.delta_pad     = r[7:4];
            build_random_set(a, int'(r[1:0]) * 48);
            build_random_set(b, int'(r[1:0]) * 48);
            @(posedge clock);
            gem_a <= a;
            gem_b <= b;
            cfg   <= c;
            @(negedge clock);
            if (n > 0) compare_outputs(prev, $sformatf("random set %0d", n - 1));
            prev = reference_result(a, b, c);
        end
        @(negedge clock);
        compare_outputs(prev, "random set 199");
        report_test("random back to back");
    endtask

    initial begin
        rst   <= 1'b1;
        gem_a <= '0;
        gem_b <= '0;
        cfg   <= '0;
        repeat (4) @(posedge clock);
        rst <= 1'b0;
        wait_for_outputs('0, 8, "outputs to clear after reset");
        exact_pad_match();
        delta_window();
        neighbor_roll_folding();
        validity_and_reset();
        random_back_to_back();
        $display("checks passed %0d, checks failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* tb/copad_props.sv */
//--------------------------------------------------
// assertions on the combiner outputs, bound into copad_combine
//--------------------------------------------------
`timescale 1ns/1ps

module copad_props (
    input logic                  clock,
    input logic                  rst,
    input logic                  neighbor_roll,
    input copad_pkg::match_vec_t match_same,
    input copad_pkg::match_vec_t match,
    input copad_pkg::match_vec_t match_upper,
    input copad_pkg::match_vec_t match_lower,
    input logic                  any_match
);

    any_is_or: assert property (@(posedge clock) disable iff (rst)
        any_match == |match)
        else $error("any_match differs from the OR of match");

    // one cycle after rst every output is cleared
    reset_clears: assert property (@(posedge clock)
        rst |=> (match == '0) && (match_upper == '0) && (match_lower == '0) && !any_match)
        else $error("outputs not cleared after rst");

    same_roll_only: assert property (@(posedge clock) disable iff (rst)
        !neighbor_roll |=> (match & ~$past(match_same)) == '0)
        else $error("match has bits outside the same-roll result");

endmodule

bind copad_combine copad_props u_copad_props (
    .clock         (clock),
    .rst           (rst),
    .neighbor_roll (neighbor_roll),
    .match_same    (match_same),
    .match         (match),
    .match_upper   (match_upper),
    .match_lower   (match_lower),
    .any_match     (any_match)
);
